//--- files.f
logic/nic_pkg.sv
logic/pnode.sv
logic/nic_ager.sv
logic/node_ring.sv
logic/host_port.sv
logic/ring_sys.sv
sim/ring_sys_sva.sv
sim/tb_ring_sys.sv

//--- sim/tb_ring_sys.sv
// =========================================================================
// Random reads and writes checked against a register model, then bursts
// Responses inside a burst may return in any order and are paired by content
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_ring_sys;

	localparam int TXNS = 300;
	// Every request gets two full drop periods of budget
	localparam int TIMEOUT = TXNS * 2 * int'(nic_pkg::AGE_MAX) * (nic_pkg::NODES + 1);
	// No node answers this id
	localparam logic [nic_pkg::ID_W-1:0] BAD_ID = 6'd40;

	logic              clk_i;
	logic              rst_i;
	logic              cmd_valid_i;
	nic_pkg::packet_t  cmd_i;
	logic              busy_o;
	nic_pkg::packet_t  rsp_o;
	nic_pkg::ipacket_t irq_o;
	logic              drop_o;

	// Expected contents of every node register
	logic [nic_pkg::DATA_W-1:0] model [1:nic_pkg::NODES][0:nic_pkg::REGS-1];

	// Host side events, collected on the falling edge
	nic_pkg::packet_t  rsp_q[$];
	nic_pkg::ipacket_t irq_q[$];
	// Responses still owed for requests already issued
	nic_pkg::packet_t  exp_q[$];
	int unsigned       drop_cnt = 0;
	int unsigned       cycles = 0;
	integer            seed;

	ring_sys ring_sys_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cmd_valid_i(cmd_valid_i),
		.cmd_i(cmd_i),
		.busy_o(busy_o),
		.rsp_o(rsp_o),
		.irq_o(irq_o),
		.drop_o(drop_o)
	);

	initial clk_i = 1'b0;
	always #20 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles waiting for the ring to answer", cycles);
			fail_run();
		end
	end

	always @(negedge clk_i) begin
		if (ring_sys_i.ring_sys_sva_i.fail_cnt != 0) begin
			$display("A ring assertion failed before %0t", $time);
			fail_run();
		end
		if (!rst_i) begin
			if (rsp_o.valid) rsp_q.push_back(rsp_o);
			if (irq_o.valid) irq_q.push_back(irq_o);
			if (drop_o) drop_cnt++;
		end
	end

	// =========================================================================
	// Reporting and compare tasks
	// =========================================================================

	task automatic fail_run();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] got_v);
		$display("ERROR %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_v, got_v);
		fail_run();
	endtask

	task automatic check_rsp(input nic_pkg::packet_t exp_v, input nic_pkg::packet_t got_v);
		if (got_v.did !== exp_v.did) report_mismatch("rsp_o.did", exp_v.did, got_v.did);
		else if (got_v.sid !== exp_v.sid) report_mismatch("rsp_o.sid", exp_v.sid, got_v.sid);
		else if (got_v.typ !== exp_v.typ) report_mismatch("rsp_o.typ", exp_v.typ, got_v.typ);
		else if (got_v.age !== exp_v.age) report_mismatch("rsp_o.age", exp_v.age, got_v.age);
		else if (got_v.addr !== exp_v.addr) report_mismatch("rsp_o.addr", exp_v.addr, got_v.addr);
		else if (got_v.data !== exp_v.data) report_mismatch("rsp_o.data", exp_v.data, got_v.data);
	endtask

	task automatic check_irq(input nic_pkg::ipacket_t exp_v, input nic_pkg::ipacket_t got_v);
		if (got_v.sid !== exp_v.sid) report_mismatch("irq_o.sid", exp_v.sid, got_v.sid);
		else if (got_v.cause !== exp_v.cause) report_mismatch("irq_o.cause", exp_v.cause, got_v.cause);
	endtask

	task automatic check_drop(input int unsigned exp_v, input int unsigned got_v);
		if (got_v != exp_v) report_mismatch("drop_o pulse count", exp_v, got_v);
	endtask

	task automatic check_busy(input logic exp_v, input logic got_v);
		if (got_v !== exp_v) report_mismatch("busy_o", exp_v, got_v);
	endtask

	// =========================================================================
	// Stimulus and model helpers
	// =========================================================================

	// Source id and age get noise, the host port must overwrite both
	function automatic nic_pkg::packet_t make_cmd(input logic [nic_pkg::ID_W-1:0] did,
			input logic [nic_pkg::ADDR_W-1:0] addr, input logic wr, input logic [31:0] data);
		nic_pkg::packet_t p;
		p = '0;
		p.sid = $random(seed);
		p.age = $random(seed);
		p.did = did;
		p.typ = wr ? nic_pkg::PKT_WR : nic_pkg::PKT_RD;
		p.addr = addr;
		p.data = data;
		return p;
	endfunction

	// Answer a live node owes for this request, writes also update the model
	function automatic nic_pkg::packet_t expect_rsp(input nic_pkg::packet_t cmd);
		nic_pkg::packet_t r;
		r = '0;
		r.valid = 1'b1;
		r.did = nic_pkg::HOST_ID;
		r.sid = cmd.did;
		r.addr = cmd.addr;
		if (cmd.typ == nic_pkg::PKT_WR) begin
			r.typ = nic_pkg::PKT_WACK;
			r.data = cmd.data;
			model[cmd.did][cmd.addr] = cmd.data;
		end else begin
			r.typ = nic_pkg::PKT_RDATA;
			r.data = model[cmd.did][cmd.addr];
		end
		return r;
	endfunction

	// Busy is sampled low on a falling edge, so the next rising edge may strobe
	task automatic issue(input nic_pkg::packet_t cmd);
		@(negedge clk_i);
		while (busy_o) @(negedge clk_i);
		@(posedge clk_i);
		cmd_valid_i <= 1'b1;
		cmd_i <= cmd;
		@(posedge clk_i);
		cmd_valid_i <= 1'b0;
		// The request slot at the host is always empty here, so busy lasts one clock
		@(negedge clk_i);
		check_busy(1'b1, busy_o);
		@(negedge clk_i);
		check_busy(1'b0, busy_o);
	endtask

	task automatic wait_events(input int unsigned n_rsp, input int unsigned n_irq,
			input int unsigned n_drop);
		while (rsp_q.size() < n_rsp || irq_q.size() < n_irq || drop_cnt < n_drop) begin
			@(posedge clk_i);
		end
	endtask

	task automatic expect_quiet();
		if (rsp_q.size() != 0 || irq_q.size() != 0) begin
			$display("Response or interrupt at %0t that no request asked for", $time);
			fail_run();
		end
		check_drop(0, drop_cnt);
	endtask

	// Pair each response with the request it answers, in any order
	task automatic match_rsps();
		nic_pkg::packet_t got;
		int idx;
		wait_events(exp_q.size(), 0, 0);
		while (rsp_q.size() > 0) begin
			got = rsp_q.pop_front();
			idx = -1;
			foreach (exp_q[i]) begin
				if (exp_q[i].sid == got.sid && exp_q[i].addr == got.addr &&
						exp_q[i].typ == got.typ) idx = i;
			end
			if (idx < 0) begin
				$display("Response from node %0d register %0d matches no request",
					got.sid, got.addr);
				fail_run();
			end else begin
				check_rsp(exp_q[idx], got);
				exp_q.delete(idx);
			end
		end
		expect_quiet();
	endtask

	// =========================================================================
	// Test sequence
	// =========================================================================

	initial begin
		nic_pkg::packet_t            cmd;
		nic_pkg::ipacket_t           exp_irq;
		logic [nic_pkg::ID_W-1:0]    did;
		logic [nic_pkg::ADDR_W-1:0]  addrs [1:nic_pkg::NODES];
		logic                        wr;
		rst_i <= 1'b1;
		cmd_valid_i <= 1'b0;
		cmd_i <= '0;
		seed = 32'h1bc2_5162;
		foreach (model[k, a]) model[k][a] = '0;
		repeat (4) @(posedge clk_i);
		rst_i <= 1'b0;

		// One request at a time, about one in ten to a node that does not exist
		for (int n = 0; n < TXNS; n++) begin
			wr = $random(seed);
			did = ({$random(seed)} % 10 == 0) ? BAD_ID : 6'(1 + {$random(seed)} % nic_pkg::NODES);
			cmd = make_cmd(did, $random(seed), wr, $random(seed));
			issue(cmd);
			if (did == BAD_ID) begin
				wait_events(0, 0, 1);
				// A second copy of the request would drop a lap or more later
				repeat (2 * (nic_pkg::NODES + 1)) @(posedge clk_i);
				check_drop(1, drop_cnt);
				drop_cnt = 0;
				expect_quiet();
			end else begin
				exp_q.push_back(expect_rsp(cmd));
				if (wr && cmd.addr == nic_pkg::IRQ_REG) begin
					exp_irq = '0;
					exp_irq.valid = 1'b1;
					exp_irq.sid = did;
					exp_irq.cause = cmd.data[7:0];
					wait_events(0, 1, 0);
					check_irq(exp_irq, irq_q.pop_front());
				end
				match_rsps();
			end
		end

		// Read straight after a write to the same register
		for (int n = 0; n < 16; n++) begin
			did = 6'(1 + {$random(seed)} % nic_pkg::NODES);
			addrs[1] = {$random(seed)} % nic_pkg::IRQ_REG;
			cmd = make_cmd(did, addrs[1], 1'b1, $random(seed));
			exp_q.push_back(expect_rsp(cmd));
			issue(cmd);
			cmd = make_cmd(did, addrs[1], 1'b0, $random(seed));
			exp_q.push_back(expect_rsp(cmd));
			issue(cmd);
			match_rsps();
		end

		// One write to every node back to back, then the same registers read back
		for (int k = 1; k <= nic_pkg::NODES; k++) begin
			addrs[k] = {$random(seed)} % nic_pkg::IRQ_REG;
			cmd = make_cmd(6'(k), addrs[k], 1'b1, $random(seed));
			exp_q.push_back(expect_rsp(cmd));
			issue(cmd);
		end
		match_rsps();
		for (int k = 1; k <= nic_pkg::NODES; k++) begin
			cmd = make_cmd(6'(k), addrs[k], 1'b0, $random(seed));
			exp_q.push_back(expect_rsp(cmd));
			issue(cmd);
		end
		match_rsps();

		// Long enough for any stray request to age out
		repeat ((int'(nic_pkg::AGE_MAX) + 2) * (nic_pkg::NODES + 1)) @(posedge clk_i);
		expect_quiet();
		if (ring_sys_i.ring_sys_sva_i.fail_cnt != 0) begin
			$display("Ring assertions failed %0d times", ring_sys_i.ring_sys_sva_i.fail_cnt);
			fail_run();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/ring_sys_sva.sv
// =========================================================================
// Checks on the host outputs of the ring system
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

module ring_sys_sva (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire logic              busy_o,
	input  wire nic_pkg::packet_t  rsp_o,
	input  wire nic_pkg::ipacket_t irq_o,
	input  wire logic              drop_o
);

	// Number of assertion failures so far
	int unsigned fail_cnt = 0;

	// No command can be held straight out of reset
	a_busy_reset: assert property (@(posedge clk_i) rst_i |=> !busy_o)
		else begin
			fail_cnt++;
			$error("busy_o high in the cycle after reset");
		end

	// Only host-addressed responses reach the strobe
	a_rsp_did: assert property (@(posedge clk_i) disable iff (rst_i)
		rsp_o.valid |-> (rsp_o.did == nic_pkg::HOST_ID))
		else begin
			fail_cnt++;
			$error("rsp_o valid with did %0d", rsp_o.did);
		end

	// A single dropped request gives a single pulse
	a_drop_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		drop_o |=> !drop_o)
		else begin
			fail_cnt++;
			$error("drop_o high for two cycles");
		end

	// Interrupts come only from real nodes
	a_irq_sid: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_o.valid |-> (irq_o.sid >= 1) && (irq_o.sid <= nic_pkg::NODES))
		else begin
			fail_cnt++;
			$error("irq_o valid with sid %0d", irq_o.sid);
		end

endmodule

bind ring_sys ring_sys_sva ring_sys_sva_i (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.busy_o(busy_o),
	.rsp_o(rsp_o),
	.irq_o(irq_o),
	.drop_o(drop_o)
);

`default_nettype wire

//--- logic/ring_sys.sv
// =========================================================================
// Closed three-ring system, host port followed by the node chain
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

module ring_sys (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire logic              cmd_valid_i,
	input  wire nic_pkg::packet_t  cmd_i,
	output logic                   busy_o,
	output nic_pkg::packet_t       rsp_o,
	output nic_pkg::ipacket_t      irq_o,
	output logic                   drop_o
);

	// Segments leaving the host port toward node 1
	nic_pkg::packet_t  req_fwd;
	nic_pkg::packet_t  rsp_fwd;
	nic_pkg::ipacket_t irq_fwd;

	// Segments coming back from the ager into the host port
	nic_pkg::packet_t  req_ret;
	nic_pkg::packet_t  rsp_ret;
	nic_pkg::ipacket_t irq_ret;

	host_port host_port_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cmd_valid_i(cmd_valid_i),
		.cmd_i(cmd_i),
		.busy_o(busy_o),
		.req_ring_i(req_ret),
		.rsp_ring_i(rsp_ret),
		.irq_ring_i(irq_ret),
		.req_ring_o(req_fwd),
		.rsp_ring_o(rsp_fwd),
		.irq_ring_o(irq_fwd),
		.rsp_o(rsp_o),
		.irq_o(irq_o)
	);

	node_ring node_ring_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.packet_i(req_fwd),
		.packet_o(req_ret),
		.rpacket_i(rsp_fwd),
		.rpacket_o(rsp_ret),
		.ipacket_i(irq_fwd),
		.ipacket_o(irq_ret),
		.drop_o(drop_o)
	);

endmodule

`default_nettype wire

//--- logic/host_port.sv
// =========================================================================
// Host side of the ring, one outstanding request, no handshake beyond busy
// Ring path is combinational here, so it adds no clock to a lap
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

module host_port (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire logic              cmd_valid_i,
	input  wire nic_pkg::packet_t  cmd_i,
	output logic                   busy_o,
	input  wire nic_pkg::packet_t  req_ring_i,
	input  wire nic_pkg::packet_t  rsp_ring_i,
	input  wire nic_pkg::ipacket_t irq_ring_i,
	output nic_pkg::packet_t       req_ring_o,
	output nic_pkg::packet_t       rsp_ring_o,
	output nic_pkg::ipacket_t      irq_ring_o,
	output nic_pkg::packet_t       rsp_o,
	output nic_pkg::ipacket_t      irq_o
);

	// Request waiting for a free slot
	nic_pkg::packet_t held;

	logic ins;
	logic rsp_take;

	// =========================================================================
	// Ring closure
	// =========================================================================

	// The held request drops into the first empty request slot
	assign ins = busy_o && !req_ring_i.valid;
	// Unclaimed requests go round again
	assign req_ring_o = ins ? held : req_ring_i;

	// Responses for the host end their trip here
	assign rsp_take = rsp_ring_i.valid && (rsp_ring_i.did == nic_pkg::HOST_ID);
	assign rsp_ring_o = rsp_take ? '0 : rsp_ring_i;

	// Every interrupt is for the host, so the ring leaves here empty
	assign irq_ring_o = '0;

	// =========================================================================
	// Request holding register
	// =========================================================================

	always_ff @(posedge clk_i) begin
		if (cmd_valid_i && !busy_o) begin
			held <= cmd_i;
			held.valid <= 1'b1;
			held.sid <= nic_pkg::HOST_ID;
			held.age <= '0;
		end
	end

	// Busy covers the cycles from acceptance until the slot is taken
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_o <= 1'b0;
		end else if (cmd_valid_i && !busy_o) begin
			busy_o <= 1'b1;
		end else if (ins) begin
			busy_o <= 1'b0;
		end
	end

	// =========================================================================
	// Host strobes
	// =========================================================================

	// Each valid bit is high for exactly the clock after extraction
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rsp_o <= '0;
			irq_o <= '0;
		end else begin
			rsp_o <= rsp_take ? rsp_ring_i : '0;
			irq_o <= irq_ring_i.valid ? irq_ring_i : '0;
		end
	end

endmodule

`default_nettype wire

//--- logic/node_ring.sv
// =========================================================================
// Chain of NODES registered nodes closed by the ager, N+1 clocks end to end
// Node ids are fixed by position, the first node has id 1
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

module node_ring (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire nic_pkg::packet_t  packet_i,
	output nic_pkg::packet_t       packet_o,
	input  wire nic_pkg::packet_t  rpacket_i,
	output nic_pkg::packet_t       rpacket_o,
	input  wire nic_pkg::ipacket_t ipacket_i,
	output nic_pkg::ipacket_t      ipacket_o,
	output logic                   drop_o
);

	// Slot k feeds node k+1, and the last slot feeds the ager
	nic_pkg::packet_t  [nic_pkg::NODES:0] pkts;
	nic_pkg::packet_t  [nic_pkg::NODES:0] rpkts;
	nic_pkg::ipacket_t [nic_pkg::NODES:0] ipkts;

	assign pkts[0] = packet_i;
	assign rpkts[0] = rpacket_i;
	assign ipkts[0] = ipacket_i;

	// =========================================================================
	// Node chain
	// =========================================================================

	for (genvar g = 0; g < nic_pkg::NODES; g++) begin : g_node
		pnode pnode_i (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.id_i(nic_pkg::ID_W'(g + 1)),
			.packet_i(pkts[g]),
			.packet_o(pkts[g+1]),
			.rpacket_i(rpkts[g]),
			.rpacket_o(rpkts[g+1]),
			.ipacket_i(ipkts[g]),
			.ipacket_o(ipkts[g+1])
		);
	end

	// Ager sits between the last node and the host port
	nic_ager nic_ager_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.packet_i(pkts[nic_pkg::NODES]),
		.packet_o(packet_o),
		.rpacket_i(rpkts[nic_pkg::NODES]),
		.rpacket_o(rpacket_o),
		.ipacket_i(ipkts[nic_pkg::NODES]),
		.ipacket_o(ipacket_o),
		.drop_o(drop_o)
	);

endmodule

`default_nettype wire

//--- logic/nic_ager.sv
// =========================================================================
// Last stage before the host, one register on each ring
// Only request slots age; responses and interrupts pass untouched
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

module nic_ager (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire nic_pkg::packet_t  packet_i,
	output nic_pkg::packet_t       packet_o,
	input  wire nic_pkg::packet_t  rpacket_i,
	output nic_pkg::packet_t       rpacket_o,
	input  wire nic_pkg::ipacket_t ipacket_i,
	output nic_pkg::ipacket_t      ipacket_o,
	output logic                   drop_o
);

	logic             expired;
	nic_pkg::packet_t aged;

	// A request that has already made AGE_MAX laps is taken off the ring
	assign expired = packet_i.valid && (packet_i.age == nic_pkg::AGE_MAX);

	// Count one more lap on live requests, empty slots stay as they are
	always_comb begin
		aged = packet_i;
		if (packet_i.valid) begin
			aged.age = packet_i.age + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			packet_o <= '0;
			rpacket_o <= '0;
			ipacket_o <= '0;
			drop_o <= 1'b0;
		end else begin
			packet_o <= expired ? '0 : aged;
			rpacket_o <= rpacket_i;
			ipacket_o <= ipacket_i;
			// One clock pulse per dropped request
			drop_o <= expired;
		end
	end

endmodule

`default_nettype wire

//--- logic/pnode.sv
// =========================================================================
// One ring stage, all three slots registered, no stall on any ring
// A request is served only when the response slot beside it is empty
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

module pnode (
	input  wire logic                   clk_i,
	input  wire logic                   rst_i,
	input  wire logic [nic_pkg::ID_W-1:0] id_i,
	input  wire nic_pkg::packet_t       packet_i,
	output nic_pkg::packet_t            packet_o,
	input  wire nic_pkg::packet_t       rpacket_i,
	output nic_pkg::packet_t            rpacket_o,
	input  wire nic_pkg::ipacket_t      ipacket_i,
	output nic_pkg::ipacket_t           ipacket_o
);

	// Register file of the node
	logic [nic_pkg::DATA_W-1:0] regs [0:nic_pkg::REGS-1];

	// Pending interrupt and the cause it will carry
	logic                        irq_pend;
	logic [nic_pkg::CAUSE_W-1:0] irq_cause;

	logic              hit;
	logic              is_wr;
	logic              irq_wr;
	logic              irq_fire;
	nic_pkg::packet_t  rsp;
	nic_pkg::ipacket_t irq_pkt;

	// =========================================================================
	// Request decode
	// =========================================================================

	// Claim the request only if it is ours and a response can go out now
	assign hit = packet_i.valid && (packet_i.did == id_i) && !rpacket_i.valid;
	// Anything that is not a write is served as a read
	assign is_wr = (packet_i.typ == nic_pkg::PKT_WR);
	assign irq_wr = hit && is_wr && (packet_i.addr == nic_pkg::IRQ_REG);
	// A pending interrupt waits for an empty slot on the interrupt ring
	assign irq_fire = irq_pend && !ipacket_i.valid;

	// Response built from the request in flight
	always_comb begin
		rsp = '0;
		rsp.valid = 1'b1;
		rsp.did = nic_pkg::HOST_ID;
		rsp.sid = id_i;
		rsp.typ = is_wr ? nic_pkg::PKT_WACK : nic_pkg::PKT_RDATA;
		rsp.addr = packet_i.addr;
		// Writes echo their data, reads return the current register
		rsp.data = is_wr ? packet_i.data : regs[packet_i.addr];
	end

	// Interrupt slot contents when the pending flag is drained
	always_comb begin
		irq_pkt.valid = 1'b1;
		irq_pkt.sid = id_i;
		irq_pkt.cause = irq_cause;
	end

	// =========================================================================
	// Ring stage registers
	// =========================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			packet_o <= '0;
			rpacket_o <= '0;
			ipacket_o <= '0;
		end else begin
			// A served request leaves an empty slot behind
			packet_o <= hit ? '0 : packet_i;
			rpacket_o <= hit ? rsp : rpacket_i;
			ipacket_o <= irq_fire ? irq_pkt : ipacket_i;
		end
	end

	// =========================================================================
	// Register file and interrupt state
	// =========================================================================

	// Registers read as zero until written
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < nic_pkg::REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (hit && is_wr) begin
			regs[packet_i.addr] <= packet_i.data;
		end
	end

	// A new write to the interrupt register wins over draining the flag
	// A second write before the drain simply replaces the cause
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			irq_pend <= 1'b0;
			irq_cause <= '0;
		end else if (irq_wr) begin
			irq_pend <= 1'b1;
			irq_cause <= packet_i.data[nic_pkg::CAUSE_W-1:0];
		end else if (irq_fire) begin
			irq_pend <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/nic_pkg.sv
// =========================================================================
// Ring sizes and slot formats shared by every ring stage and the host port
// Node ids run from 1 to NODES, and id 0 is reserved for the host
// =========================================================================
`default_nettype none

package nic_pkg;

	// =========================================================================
	// Ring geometry
	// =========================================================================

	// Number of processing nodes on the ring
	localparam int NODES = 8;
	// Width of the source and destination id fields
	localparam int ID_W = 6;
	// Registers held by each node
	localparam int REGS = 16;
	// Register address width follows from the register count
	localparam int ADDR_W = $clog2(REGS);
	// Width of the lap counter carried by requests
	localparam int AGE_W = 4;
	// Payload width of a request or response
	localparam int DATA_W = 32;
	// Width of the interrupt cause field
	localparam int CAUSE_W = 8;

	// Responses are always addressed to the host
	localparam logic [ID_W-1:0] HOST_ID = '0;
	// A write to this register raises an interrupt
	localparam logic [ADDR_W-1:0] IRQ_REG = 4'd15;
	// A request seen by the ager with this age is dropped
	localparam logic [AGE_W-1:0] AGE_MAX = 4'd15;

	// =========================================================================
	// Slot formats
	// =========================================================================

	// Requests use the first two codes and responses the last two
	typedef enum logic [1:0] {
		PKT_WR    = 2'd0,
		PKT_RD    = 2'd1,
		PKT_WACK  = 2'd2,
		PKT_RDATA = 2'd3
	} pkt_type_t;

	// Slot on the request and response rings, 55 bits in all
	typedef struct packed {
		logic              valid;
		logic [ID_W-1:0]   did;
		logic [ID_W-1:0]   sid;
		pkt_type_t         typ;
		logic [AGE_W-1:0]  age;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} packet_t;

	// Slot on the interrupt ring
	typedef struct packed {
		logic               valid;
		logic [ID_W-1:0]    sid;
		logic [CAUSE_W-1:0] cause;
	} ipacket_t;

endpackage

`default_nettype wire
